// ==== baud_gen.sv ====
`timescale 1ns/1ps
// All four ticks are one MCLK wide and coincide with the base tick
// PRESCALE of 1 gives a tick on every MCLK
module baud_gen
#(
	parameter int PRESCALE = 2
)
(
	input  logic MCLK,
	input  logic reset_i,
	output serial_pkg::baud_tick_t tick_o
);
	localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam logic [PW-1:0] PRE_LAST = PW'(PRESCALE - 1);

	logic [PW-1:0] pre_q;
	logic [3:0] div_q;
	logic base_tick;

	assign base_tick = (pre_q == PRE_LAST);

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			pre_q <= '0;
			div_q <= '0;
		end
		else if (base_tick)
		begin
			pre_q <= '0;
			div_q <= div_q + 4'd1;
		end
		else
			pre_q <= pre_q + 1'b1;
	end

	// Divide by 2, 4 and 16
	assign tick_o[0] = base_tick;
	assign tick_o[1] = base_tick & div_q[0];
	assign tick_o[2] = base_tick & (&div_q[1:0]);
	assign tick_o[3] = base_tick & (&div_q);

endmodule

// ==== bus_decode.sv ====
`timescale 1ns/1ps
// Purely combinational; at most one strobe is active per bus cycle
// rx_rd follows rd_i, all other strobes follow wr_i
module bus_decode
(
	input  io_bus_pkg::reg_addr_t addr_i,
	input  logic wr_i,
	input  logic rd_i,
	output serial_pkg::port_strobe_t [io_bus_pkg::NUM_PORTS-1:0] strobe_o
);
	import io_bus_pkg::*;

	always_comb
	begin
		strobe_o = '0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (addr_i == reg_addr_t'(ADDR_DATA_BASE + p))
				strobe_o[p].data_we = wr_i;

			if (addr_i == reg_addr_t'(ADDR_CTRL_BASE + p))
				strobe_o[p].ctrl_we = wr_i;

			if (addr_i == reg_addr_t'(ADDR_SER_BASE + SER_STRIDE * p))
				strobe_o[p].tx_we = wr_i;

			// Reading rx data acknowledges the byte
			if (addr_i == reg_addr_t'(ADDR_SER_BASE + SER_STRIDE * p + 1))
				strobe_o[p].rx_rd = rd_i;

			if (addr_i == reg_addr_t'(ADDR_SER_BASE + SER_STRIDE * p + 2))
				strobe_o[p].sctrl_we = wr_i;
		end
	end

endmodule

// ==== ctrl_port.sv ====
`timescale 1ns/1ps
// One controller port; tx_en and rx_en override the direction of pins 4 and 5
// Pin inputs are used unsynchronized for readback and the pin interrupt
module ctrl_port
(
	input  logic MCLK,
	input  logic reset_i,
	input  io_bus_pkg::byte_t wdata_i,
	input  serial_pkg::port_strobe_t strobe_i,
	input  serial_pkg::baud_tick_t tick_i,
	input  serial_pkg::pin_vec_t pin_i,
	output serial_pkg::pin_vec_t pin_o,
	output serial_pkg::pin_vec_t pin_oe_o,
	output serial_pkg::port_view_t view_o
);
	import io_bus_pkg::*;
	import serial_pkg::*;

	byte_t data_q;
	byte_t ctrl_q;
	serial_ctrl_t sctrl_q;
	logic tick_sel;
	logic tx_line;
	byte_t tx_data;
	logic tx_full;
	byte_t rx_data;
	logic rx_ready;
	logic rx_error;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			data_q <= '0;
			ctrl_q <= '0;
			sctrl_q <= '0;
		end
		else
		begin
			if (strobe_i.data_we)
				data_q <= wdata_i;
			if (strobe_i.ctrl_we)
				ctrl_q <= wdata_i;
			if (strobe_i.sctrl_we)
				sctrl_q <= serial_ctrl_t'(wdata_i[7:3]);
		end
	end

	assign tick_sel = tick_i[sctrl_q.baud_sel];

	uart_tx u_tx (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.enable_i(sctrl_q.tx_en),
		.tick_i(tick_sel),
		.load_i(strobe_i.tx_we),
		.data_i(wdata_i),
		.tx_data_o(tx_data),
		.tx_full_o(tx_full),
		.line_o(tx_line)
	);

	uart_rx u_rx (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.enable_i(sctrl_q.rx_en),
		.tick_i(tick_sel),
		.line_i(pin_i[RX_PIN]),
		.ack_i(strobe_i.rx_rd),
		.rx_data_o(rx_data),
		.rx_ready_o(rx_ready),
		.rx_error_o(rx_error)
	);

	always_comb
	begin
		pin_oe_o = ctrl_q[6:0];
		pin_o = data_q[6:0];
		if (sctrl_q.tx_en)
		begin
			pin_oe_o[TX_PIN] = 1'b1;
			pin_o[TX_PIN] = tx_line;
		end
		if (sctrl_q.rx_en)
			pin_oe_o[RX_PIN] = 1'b0;
	end

	always_comb
	begin
		// Data readback is bit 7 of the register over the live pins
		view_o.data_q = {data_q[7], pin_i};
		view_o.ctrl_q = ctrl_q;
		view_o.tx_data = tx_data;
		view_o.rx_data = rx_data;
		view_o.sctrl = sctrl_q;
		view_o.rx_error = rx_error;
		view_o.rx_ready = rx_ready;
		view_o.tx_full = tx_full;
		view_o.irq_pin = ~pin_i[IRQ_PIN] & ctrl_q[7];
		view_o.irq_rx = rx_ready & sctrl_q.rx_int_en;
	end

endmodule

// ==== io_bus_pkg.sv ====
// Register map of the sixteen byte registers on the host bus
// All sixteen addresses decode; there are no holes in the map
package io_bus_pkg;

	localparam int NUM_PORTS = 3;

	typedef logic [7:0] byte_t;
	typedef logic [3:0] reg_addr_t;

	// Fixed version byte at address 0
	localparam int ADDR_VERSION = 0;

	// Parallel data at 1..3, parallel control at 4..6
	localparam int ADDR_DATA_BASE = 1;
	localparam int ADDR_CTRL_BASE = 4;

	// Port n: tx data, rx data, serial control/status
	localparam int ADDR_SER_BASE = 7;
	localparam int SER_STRIDE = 3;

endpackage

// ==== io_ctrl_top.sv ====
`timescale 1ns/1ps
// Three-port I/O controller on a simple byte register bus
// int_o is an active-high level, pins are indexed by port
module io_ctrl_top
#(
	parameter int PRESCALE = 2,
	parameter io_bus_pkg::byte_t VERSION = 8'h01
)
(
	input  logic MCLK,
	input  logic reset_i,
	input  io_bus_pkg::reg_addr_t addr_i,
	input  io_bus_pkg::byte_t wdata_i,
	input  logic wr_i,
	input  logic rd_i,
	output io_bus_pkg::byte_t rdata_o,
	input  serial_pkg::pin_vec_t [io_bus_pkg::NUM_PORTS-1:0] pins_i,
	output serial_pkg::pin_vec_t [io_bus_pkg::NUM_PORTS-1:0] pins_o,
	output serial_pkg::pin_vec_t [io_bus_pkg::NUM_PORTS-1:0] pins_oe_o,
	output logic int_o
);
	import io_bus_pkg::*;
	import serial_pkg::*;

	port_strobe_t [NUM_PORTS-1:0] strobe;
	port_view_t [NUM_PORTS-1:0] view;
	baud_tick_t tick;

	baud_gen #(.PRESCALE(PRESCALE)) u_baud (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.tick_o(tick)
	);

	bus_decode u_decode (
		.addr_i(addr_i),
		.wr_i(wr_i),
		.rd_i(rd_i),
		.strobe_o(strobe)
	);

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		ctrl_port u_port (
			.MCLK(MCLK),
			.reset_i(reset_i),
			.wdata_i(wdata_i),
			.strobe_i(strobe[p]),
			.tick_i(tick),
			.pin_i(pins_i[p]),
			.pin_o(pins_o[p]),
			.pin_oe_o(pins_oe_o[p]),
			.view_o(view[p])
		);
	end

	read_mux #(.VERSION(VERSION)) u_rmux (
		.addr_i(addr_i),
		.view_i(view),
		.rdata_o(rdata_o),
		.int_o(int_o)
	);

endmodule

// ==== read_mux.sv ====
`timescale 1ns/1ps
// Read data is combinational from the address, no read strobe needed
module read_mux
#(
	parameter io_bus_pkg::byte_t VERSION = 8'h01
)
(
	input  io_bus_pkg::reg_addr_t addr_i,
	input  serial_pkg::port_view_t [io_bus_pkg::NUM_PORTS-1:0] view_i,
	output io_bus_pkg::byte_t rdata_o,
	output logic int_o
);
	import io_bus_pkg::*;

	always_comb
	begin
		rdata_o = '0;
		if (addr_i == reg_addr_t'(ADDR_VERSION))
			rdata_o = VERSION;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (addr_i == reg_addr_t'(ADDR_DATA_BASE + p))
				rdata_o = view_i[p].data_q;
			if (addr_i == reg_addr_t'(ADDR_CTRL_BASE + p))
				rdata_o = view_i[p].ctrl_q;
			if (addr_i == reg_addr_t'(ADDR_SER_BASE + SER_STRIDE * p))
				rdata_o = view_i[p].tx_data;
			if (addr_i == reg_addr_t'(ADDR_SER_BASE + SER_STRIDE * p + 1))
				rdata_o = view_i[p].rx_data;
			// Status: control bits over error, ready, full
			if (addr_i == reg_addr_t'(ADDR_SER_BASE + SER_STRIDE * p + 2))
				rdata_o = {view_i[p].sctrl, view_i[p].rx_error,
					view_i[p].rx_ready, view_i[p].tx_full};
		end
	end

	always_comb
	begin
		int_o = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
			int_o = int_o | view_i[p].irq_pin | view_i[p].irq_rx;
	end

endmodule

// ==== serial_pkg.sv ====
// Per-port types for the pin, register and serial logic
// Serial control is written from bus data bits 7:3
package serial_pkg;

	typedef logic [6:0] pin_vec_t;
	typedef logic [3:0] baud_tick_t;

	localparam int TX_PIN = 4;
	localparam int RX_PIN = 5;
	localparam int IRQ_PIN = 6;
	localparam int OVERSAMPLE = 16;

	typedef struct packed {
		logic [1:0] baud_sel;
		logic rx_en;
		logic tx_en;
		logic rx_int_en;
	} serial_ctrl_t;

	// One-cycle strobes from the decoder
	typedef struct packed {
		logic data_we;
		logic ctrl_we;
		logic tx_we;
		logic sctrl_we;
		logic rx_rd;
	} port_strobe_t;

	typedef struct packed {
		io_bus_pkg::byte_t data_q;
		io_bus_pkg::byte_t ctrl_q;
		io_bus_pkg::byte_t tx_data;
		io_bus_pkg::byte_t rx_data;
		serial_ctrl_t sctrl;
		logic rx_error;
		logic rx_ready;
		logic tx_full;
		logic irq_pin;
		logic irq_rx;
	} port_view_t;

endpackage

// ==== src.f ====
io_bus_pkg.sv
serial_pkg.sv
baud_gen.sv
bus_decode.sv
uart_tx.sv
uart_rx.sv
ctrl_port.sv
read_mux.sv
io_ctrl_top.sv
tb_io_ctrl.sv

// ==== tb_io_ctrl.sv ====
`timescale 1ns/1ps
// Port n tx pin feeds port n+1 rx pin only while its loop enable is set
// Otherwise every pin input comes from the testbench pin drive
module tb_io_ctrl;
	import io_bus_pkg::*;
	import serial_pkg::*;

	localparam int PRESCALE = 2;
	localparam byte_t VERSION = 8'h01;
	localparam int BIT_CYCLES = PRESCALE * OVERSAMPLE;
	localparam int WAIT_LIMIT = 2000;

	typedef enum logic [3:0] {
		OP_WRITE, OP_READ, OP_ACK, OP_PINS, OP_LOOP, OP_OUT, OP_OE, OP_INT, OP_WAIT, OP_BANG
	} op_e;

	// For pin and loop ops addr holds a port index
	typedef struct packed {
		op_e op;
		reg_addr_t addr;
		byte_t data;
		byte_t exp;
	} step_t;

	logic MCLK = 1'b0;
	logic reset_i;
	reg_addr_t addr_i;
	byte_t wdata_i;
	logic wr_i;
	logic rd_i;
	byte_t rdata_o;
	pin_vec_t [NUM_PORTS-1:0] pins_i;
	pin_vec_t [NUM_PORTS-1:0] pins_o;
	pin_vec_t [NUM_PORTS-1:0] pins_oe_o;
	logic int_o;

	pin_vec_t [NUM_PORTS-1:0] pin_drv;
	logic [NUM_PORTS-1:0] loop_en;
	step_t steps[$];
	int mismatches = 0;
	int timeouts = 0;

	io_ctrl_top #(.PRESCALE(PRESCALE), .VERSION(VERSION)) DUT (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.wr_i(wr_i),
		.rd_i(rd_i),
		.rdata_o(rdata_o),
		.pins_i(pins_i),
		.pins_o(pins_o),
		.pins_oe_o(pins_oe_o),
		.int_o(int_o)
	);

	always #2 MCLK = ~MCLK;

	always_comb
	begin
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			pins_i[p] = pin_drv[p];
			if (loop_en[p])
				pins_i[p][RX_PIN] = pins_o[(p + NUM_PORTS - 1) % NUM_PORTS][TX_PIN];
		end
	end

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_pins(input pin_vec_t got, input pin_vec_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
			mismatches++;
		end
	endtask

	function automatic byte_t status_byte(serial_ctrl_t sc, logic err, logic rdy, logic full);
		return {sc, err, rdy, full};
	endfunction

	task automatic bus_write(input reg_addr_t a, input byte_t d);
		@(posedge MCLK);
		#1;
		addr_i = a;
		wdata_i = d;
		wr_i = 1'b1;
		@(posedge MCLK);
		#1;
		wr_i = 1'b0;
	endtask

	// Combinational read data sampled mid-cycle
	task automatic bus_read(input reg_addr_t a, input logic ack, output byte_t d);
		@(posedge MCLK);
		#1;
		addr_i = a;
		rd_i = ack;
		#1;
		d = rdata_o;
		if (ack)
		begin
			@(posedge MCLK);
			#1;
			rd_i = 1'b0;
		end
	endtask

	task automatic wait_flag(input reg_addr_t a, input byte_t mask);
		byte_t v;
		int n;
		v = '0;
		n = 0;
		while ((v & mask) == 0 && n < WAIT_LIMIT)
		begin
			bus_read(a, 1'b0, v);
			n++;
		end
		if ((v & mask) == 0)
		begin
			$display("Timeout at %0t ns: register %0d never showed flag %h", $time, a, mask);
			timeouts++;
		end
	endtask

	// Start bit, data LSB first, then the given stop level
	task automatic bit_bang(input int port, input byte_t data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge MCLK);
			#1;
			pin_drv[port][RX_PIN] = frame[i];
			repeat (BIT_CYCLES - 1) @(posedge MCLK);
		end
		@(posedge MCLK);
		#1;
		pin_drv[port][RX_PIN] = 1'b1;
	endtask

	task automatic add_step(input op_e op, input int addr, input byte_t data, input byte_t exp);
		step_t s;
		s.op = op;
		s.addr = reg_addr_t'(addr);
		s.data = data;
		s.exp = exp;
		steps.push_back(s);
	endtask

	task automatic apply_step(input step_t s);
		byte_t v;
		case (s.op)
			OP_WRITE: bus_write(s.addr, s.data);
			OP_READ:
			begin
				bus_read(s.addr, 1'b0, v);
				check_byte(v, s.exp, $sformatf("read of reg %0d", s.addr));
			end
			OP_ACK:
			begin
				bus_read(s.addr, 1'b1, v);
				check_byte(v, s.exp, $sformatf("acknowledged read of reg %0d", s.addr));
			end
			OP_PINS, OP_LOOP:
			begin
				@(posedge MCLK);
				#1;
				if (s.op == OP_PINS)
					pin_drv[s.addr] = pin_vec_t'(s.data);
				else
					loop_en[s.addr] = s.data[0];
			end
			OP_OUT, OP_OE, OP_INT:
			begin
				@(posedge MCLK);
				#2;
				if (s.op == OP_OUT)
					check_pins(pins_o[s.addr], pin_vec_t'(s.exp),
						$sformatf("pins_o[%0d]", s.addr));
				else if (s.op == OP_OE)
					check_pins(pins_oe_o[s.addr], pin_vec_t'(s.exp),
						$sformatf("pins_oe_o[%0d]", s.addr));
				else
					check_bit(int_o, s.exp[0], "int_o");
			end
			OP_WAIT: wait_flag(s.addr, s.data);
			OP_BANG: bit_bang(s.addr, s.data, s.exp[0]);
			default: $display("Unknown table operation %0d", s.op);
		endcase
	endtask

	task automatic build_table();
		byte_t d0;
		byte_t d;
		byte_t c;
		pin_vec_t r;
		byte_t b;
		byte_t f;
		byte_t rdy;
		serial_ctrl_t sc0;
		serial_ctrl_t sc1;
		serial_ctrl_t sc2;
		d0 = '0;
		rdy = status_byte('0, 1'b0, 1'b1, 1'b0);
		// Fields in order baud_sel, rx_en, tx_en, rx_int_en
		sc0 = serial_ctrl_t'({2'd0, 1'b1, 1'b1, 1'b0});
		sc1 = serial_ctrl_t'({2'd0, 1'b1, 1'b0, 1'b1});
		sc2 = serial_ctrl_t'({2'd0, 1'b1, 1'b0, 1'b0});

		// Reset state
		add_step(OP_READ, ADDR_VERSION, 8'h00, VERSION);
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			add_step(OP_READ, ADDR_CTRL_BASE + p, 8'h00, 8'h00);
			add_step(OP_READ, ADDR_SER_BASE + SER_STRIDE * p + 2, 8'h00, 8'h00);
			add_step(OP_OE, p, 8'h00, 8'h00);
		end
		add_step(OP_INT, 0, 8'h00, 8'h00);

		// Parallel I/O with ctrl bit 7 kept clear
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			d = byte_t'($urandom);
			c = byte_t'($urandom) & 8'h7F;
			r = pin_vec_t'($urandom);
			if (p == 0)
				d0 = d;
			add_step(OP_WRITE, ADDR_DATA_BASE + p, d, 8'h00);
			add_step(OP_OUT, p, 8'h00, {1'b0, d[6:0]});
			add_step(OP_WRITE, ADDR_CTRL_BASE + p, c, 8'h00);
			add_step(OP_OE, p, 8'h00, {1'b0, c[6:0]});
			add_step(OP_PINS, p, {1'b0, r}, 8'h00);
			add_step(OP_READ, ADDR_DATA_BASE + p, 8'h00, {d[7], r});
		end

		// Overrides turn the rx pin into an input and the tx pin into an output
		// Data bit 4 low so only the idle tx line can drive pin 4 high
		d0 = d0 & 8'hEF;
		add_step(OP_WRITE, ADDR_DATA_BASE, d0, 8'h00);
		add_step(OP_PINS, 0, 8'h7F, 8'h00);
		add_step(OP_WRITE, ADDR_CTRL_BASE, 8'h20, 8'h00);
		add_step(OP_WRITE, ADDR_SER_BASE + 2, status_byte(sc0, 1'b0, 1'b0, 1'b0), 8'h00);
		add_step(OP_OE, 0, 8'h00, 8'h10);
		add_step(OP_OUT, 0, 8'h00, {1'b0, d0[6:0]} | 8'h10);
		add_step(OP_READ, ADDR_SER_BASE + 2, 8'h00, status_byte(sc0, 1'b0, 1'b0, 1'b0));

		// Pin interrupt on port 2
		add_step(OP_WRITE, ADDR_CTRL_BASE + 2, 8'h80, 8'h00);
		add_step(OP_PINS, 2, 8'h7F, 8'h00);
		add_step(OP_INT, 0, 8'h00, 8'h00);
		add_step(OP_PINS, 2, 8'h3F, 8'h00);
		add_step(OP_INT, 0, 8'h00, 8'h01);
		add_step(OP_PINS, 2, 8'h7F, 8'h00);
		add_step(OP_INT, 0, 8'h00, 8'h00);
		add_step(OP_WRITE, ADDR_CTRL_BASE + 2, 8'h00, 8'h00);

		// Loopback port 0 to port 1
		b = byte_t'($urandom);
		add_step(OP_LOOP, 1, 8'h01, 8'h00);
		add_step(OP_WRITE, ADDR_SER_BASE + SER_STRIDE + 2, status_byte(sc1, 1'b0, 1'b0, 1'b0),
			8'h00);
		add_step(OP_WRITE, ADDR_SER_BASE, b, 8'h00);
		add_step(OP_WAIT, ADDR_SER_BASE + SER_STRIDE + 2, rdy, 8'h00);
		add_step(OP_READ, ADDR_SER_BASE + SER_STRIDE + 2, 8'h00,
			status_byte(sc1, 1'b0, 1'b1, 1'b0));
		add_step(OP_INT, 0, 8'h00, 8'h01);
		add_step(OP_READ, ADDR_SER_BASE, 8'h00, b);
		add_step(OP_ACK, ADDR_SER_BASE + SER_STRIDE + 1, 8'h00, b);
		add_step(OP_READ, ADDR_SER_BASE + SER_STRIDE + 2, 8'h00,
			status_byte(sc1, 1'b0, 1'b0, 1'b0));
		add_step(OP_INT, 0, 8'h00, 8'h00);

		// Framing error on port 2 with the stop bit driven low
		f = byte_t'($urandom);
		add_step(OP_WRITE, ADDR_SER_BASE + 2 * SER_STRIDE + 2,
			status_byte(sc2, 1'b0, 1'b0, 1'b0), 8'h00);
		add_step(OP_BANG, 2, f, 8'h00);
		add_step(OP_WAIT, ADDR_SER_BASE + 2 * SER_STRIDE + 2, rdy, 8'h00);
		add_step(OP_READ, ADDR_SER_BASE + 2 * SER_STRIDE + 2, 8'h00,
			status_byte(sc2, 1'b1, 1'b1, 1'b0));
		add_step(OP_ACK, ADDR_SER_BASE + 2 * SER_STRIDE + 1, 8'h00, f);
		add_step(OP_READ, ADDR_SER_BASE + 2 * SER_STRIDE + 2, 8'h00,
			status_byte(sc2, 1'b0, 1'b0, 1'b0));
	endtask

	initial
	begin
		void'($urandom(33));
		reset_i = 1'b1;
		addr_i = '0;
		wdata_i = '0;
		wr_i = 1'b0;
		rd_i = 1'b0;
		pin_drv = '1;
		loop_en = '0;
		build_table();
		repeat (3) @(posedge MCLK);
		#1;
		reset_i = 1'b0;
		foreach (steps[i])
			apply_step(steps[i]);
		repeat (4) @(posedge MCLK);
		$display("Errors: %0d value mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps
// 8N1 receiver at 16x oversampling; the line passes a two-flop synchronizer
// A new frame overwrites data and flags even if the last byte was not read
module uart_rx
(
	input  logic MCLK,
	input  logic reset_i,
	input  logic enable_i,
	input  logic tick_i,
	input  logic line_i,
	input  logic ack_i,
	output io_bus_pkg::byte_t rx_data_o,
	output logic rx_ready_o,
	output logic rx_error_o
);
	import io_bus_pkg::*;
	import serial_pkg::*;

	localparam logic [3:0] LAST_TICK = 4'(OVERSAMPLE - 1);
	localparam logic [3:0] MID_TICK = 4'(OVERSAMPLE / 2 - 1);
	localparam logic [3:0] STOP_BIT = 4'd9;

	logic [1:0] sync_q;
	logic line;
	logic active_q;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	byte_t shift_q;
	byte_t data_q;
	logic ready_q;
	logic error_q;
	logic sample;
	logic stop_hit;

	assign line = sync_q[1];

	// Start bit checked at mid-point, later bits one full bit apart
	always_comb
	begin
		if (bit_cnt == 4'd0)
			sample = enable_i & active_q & tick_i & (tick_cnt == MID_TICK);
		else
			sample = enable_i & active_q & tick_i & (tick_cnt == LAST_TICK);
	end

	assign stop_hit = sample & (bit_cnt == STOP_BIT);

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], line_i};
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			active_q <= 1'b0;
			tick_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!enable_i)
			active_q <= 1'b0;
		else if (!active_q)
		begin
			if (tick_i && !line)
			begin
				active_q <= 1'b1;
				tick_cnt <= '0;
				bit_cnt <= '0;
			end
		end
		else if (sample)
		begin
			tick_cnt <= '0;
			// False start or end of frame
			if ((bit_cnt == 4'd0 && line) || bit_cnt == STOP_BIT)
				active_q <= 1'b0;
			else
				bit_cnt <= bit_cnt + 4'd1;
		end
		else if (tick_i)
			tick_cnt <= tick_cnt + 4'd1;
	end

	always_ff @(posedge MCLK)
	begin
		if (sample && bit_cnt != 4'd0 && bit_cnt != STOP_BIT)
			shift_q <= {line, shift_q[7:1]};
		if (stop_hit)
			data_q <= shift_q;
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			ready_q <= 1'b0;
			error_q <= 1'b0;
		end
		else if (stop_hit)
		begin
			ready_q <= 1'b1;
			error_q <= ~line;
		end
		else if (ack_i)
		begin
			ready_q <= 1'b0;
			error_q <= 1'b0;
		end
	end

	assign rx_data_o = data_q;
	assign rx_ready_o = ready_q;
	assign rx_error_o = error_q;

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps
// 8N1 transmitter, one holding byte; a write while full replaces it
// Frame start is paced by the selected tick, so latency varies
module uart_tx
(
	input  logic MCLK,
	input  logic reset_i,
	input  logic enable_i,
	input  logic tick_i,
	input  logic load_i,
	input  io_bus_pkg::byte_t data_i,
	output io_bus_pkg::byte_t tx_data_o,
	output logic tx_full_o,
	output logic line_o
);
	import io_bus_pkg::*;
	import serial_pkg::*;

	localparam logic [3:0] LAST_TICK = 4'(OVERSAMPLE - 1);
	localparam logic [3:0] LAST_BIT = 4'd9;

	byte_t hold_q;
	logic full_q;
	logic busy_q;
	logic [9:0] shift_q;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic start;
	logic bit_end;

	assign start = enable_i & tick_i & full_q & ~busy_q;
	assign bit_end = busy_q & tick_i & (tick_cnt == LAST_TICK);

	always_ff @(posedge MCLK)
	begin
		if (load_i)
			hold_q <= data_i;
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			full_q <= 1'b0;
		else if (load_i)
			full_q <= 1'b1;
		else if (start)
			full_q <= 1'b0;
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			busy_q <= 1'b0;
			tick_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!enable_i)
			busy_q <= 1'b0;
		else if (start)
		begin
			busy_q <= 1'b1;
			tick_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (bit_end)
		begin
			tick_cnt <= '0;
			if (bit_cnt == LAST_BIT)
				busy_q <= 1'b0;
			else
				bit_cnt <= bit_cnt + 4'd1;
		end
		else if (busy_q && tick_i)
			tick_cnt <= tick_cnt + 4'd1;
	end

	// Stop, data LSB first, start
	always_ff @(posedge MCLK)
	begin
		if (start)
			shift_q <= {1'b1, hold_q, 1'b0};
		else if (bit_end)
			shift_q <= {1'b1, shift_q[9:1]};
	end

	assign line_o = busy_q ? shift_q[0] : 1'b1;
	assign tx_data_o = hold_q;
	assign tx_full_o = full_q;

endmodule
